// ==== design/fetch_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// FETCH_XLEN must stay 64. The fetch path selects 32-bit halves of one doubleword.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address and memory data width.
`define FETCH_XLEN 64

// first pc fetched after reset.
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// number of decoded-side queue entries.
`define FETCH_QUEUE_DEPTH 4

// most memory reads that may be in flight at once.
`define FETCH_MAX_OUTSTANDING 2

`endif

// ==== design/fetch_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// any response code other than okay is treated as an access fault.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

  typedef logic [`FETCH_XLEN-1:0] addr_t;
  typedef logic [31:0]            inst_t;
  typedef logic [`FETCH_XLEN-1:0] mem_data_t;

  // response codes use the usual AXI encodings.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } mem_resp_t;

  // one fetched instruction as it travels to decode.
  typedef struct packed {
    addr_t pc;
    inst_t inst;
    logic  fault;
  } fetch_entry_t;

endpackage

`default_nettype wire

// ==== design/pc_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// redirect targets are forced to a 4-byte boundary. No compressed instructions.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_settings.svh"

module pc_gen (
  input  logic             clk,
  input  logic             rst,
  input  logic             redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  logic             advance_i,
  output fetch_pkg::addr_t pc_o
);

  import fetch_pkg::*;

  addr_t pc_q;
  addr_t target;
  addr_t pc_next_seq;

  // the low two bits of a target are dropped.
  assign target = {redirect_pc_i[`FETCH_XLEN-1:2], 2'b00};

  assign pc_next_seq = pc_q + addr_t'(4);

  // ~~~~~~~~~~~~~~~~~~~~
  // pc register
  // ~~~~~~~~~~~~~~~~~~~~

  // a redirect from a later stage wins over the sequential step.
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (redirect_i) begin
      pc_q <= target;
    end else if (advance_i) begin
      pc_q <= pc_next_seq;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== design/fetch_req_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// responses return in request order and are always accepted. Queue space for each
// read is reserved before it is issued, so the queue cannot overflow.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_settings.svh"

module fetch_req_unit (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       redirect_i,
  input  fetch_pkg::addr_t                           pc_i,
  input  logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0]    free_slots_i,
  output logic                                       advance_o,
  output logic                                       mem_req_valid_o,
  input  logic                                       mem_req_ready_i,
  output fetch_pkg::addr_t                           mem_req_addr_o,
  input  logic                                       mem_resp_valid_i,
  input  fetch_pkg::mem_data_t                       mem_resp_data_i,
  input  fetch_pkg::mem_resp_t                       mem_resp_code_i,
  output logic                                       push_o,
  output fetch_pkg::fetch_entry_t                    push_entry_o
);

  import fetch_pkg::*;

  localparam int MAX_OUT = `FETCH_MAX_OUTSTANDING;
  localparam int CNT_W   = $clog2(MAX_OUT + 1);
  localparam int PTR_W   = (MAX_OUT > 1) ? $clog2(MAX_OUT) : 1;
  localparam int FREE_W  = $clog2(`FETCH_QUEUE_DEPTH + 1);

  // pc of every read in flight, oldest at rd_ptr.
  addr_t rec_pc [MAX_OUT];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] out_cnt;
  logic [CNT_W-1:0] discard_cnt;
  logic             issue;
  addr_t            resp_pc;

  // ~~~~~~~~~~~~~~~~~~~~
  // request side
  // ~~~~~~~~~~~~~~~~~~~~

  // every read in flight holds a queue slot, including ones that will be dropped.
  assign mem_req_valid_o = !rst && (out_cnt < CNT_W'(MAX_OUT)) &&
                           (FREE_W'(out_cnt) < free_slots_i) && !redirect_i;
  assign mem_req_addr_o  = {pc_i[`FETCH_XLEN-1:3], 3'b000};
  assign issue           = mem_req_valid_o && mem_req_ready_i;
  assign advance_o       = issue;

  always_ff @(posedge clk) begin
    if (issue) begin
      rec_pc[wr_ptr] <= pc_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      out_cnt <= '0;
    end else begin
      if (issue) begin
        wr_ptr <= (wr_ptr == PTR_W'(MAX_OUT - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (mem_resp_valid_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(MAX_OUT - 1)) ? '0 : rd_ptr + 1'b1;
      end
      out_cnt <= out_cnt + CNT_W'(issue) - CNT_W'(mem_resp_valid_i);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // response side
  // ~~~~~~~~~~~~~~~~~~~~

  // on a redirect, every read still in flight after this edge belongs to the old path.
  // nothing is issued in a redirect cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      discard_cnt <= '0;
    end else if (redirect_i) begin
      discard_cnt <= out_cnt - CNT_W'(mem_resp_valid_i);
    end else if (mem_resp_valid_i && (discard_cnt != '0)) begin
      discard_cnt <= discard_cnt - 1'b1;
    end
  end

  assign resp_pc = rec_pc[rd_ptr];

  assign push_o             = mem_resp_valid_i && (discard_cnt == '0);
  assign push_entry_o.pc    = resp_pc;
  // pc bit 2 picks the upper or lower word of the doubleword.
  assign push_entry_o.inst  = resp_pc[2] ? mem_resp_data_i[63:32] : mem_resp_data_i[31:0];
  assign push_entry_o.fault = (mem_resp_code_i != resp_okay);

endmodule

`default_nettype wire

// ==== design/fetch_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// flush wins over a push in the same cycle. Pushes into a full queue are ignored.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module fetch_fifo #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  entry_t                     push_data_i,
  output logic                       pop_valid_o,
  input  logic                       pop_ready_i,
  output entry_t                     pop_data_o,
  output logic [$clog2(DEPTH+1)-1:0] free_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_pop  = pop_valid_o && pop_ready_i;
  assign do_push = push_i && ((count != CNT_W'(DEPTH)) || do_pop);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // the head entry is held until the consumer takes it.
  assign pop_valid_o = (count != '0);
  assign pop_data_o  = mem[rd_ptr];
  assign free_o      = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// no branch prediction. Fetch runs sequentially until a redirect arrives.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_settings.svh"

module if_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 redirect_i,
  input  fetch_pkg::addr_t     redirect_pc_i,
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output fetch_pkg::addr_t     mem_req_addr_o,
  input  logic                 mem_resp_valid_i,
  input  fetch_pkg::mem_data_t mem_resp_data_i,
  input  fetch_pkg::mem_resp_t mem_resp_code_i,
  output logic                 fetch_valid_o,
  input  logic                 fetch_ready_i,
  output fetch_pkg::addr_t     fetch_pc_o,
  output fetch_pkg::inst_t     fetch_inst_o,
  output logic                 fetch_fault_o
);

  import fetch_pkg::*;

  addr_t                                    pc;
  logic                                     pc_advance;
  logic                                     push;
  fetch_entry_t                             push_entry;
  fetch_entry_t                             head_entry;
  logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0]  free_slots;

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .advance_i     (pc_advance),
    .pc_o          (pc)
  );

  fetch_req_unit u_fetch_req_unit (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect_i),
    .pc_i             (pc),
    .free_slots_i     (free_slots),
    .advance_o        (pc_advance),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .mem_resp_code_i  (mem_resp_code_i),
    .push_o           (push),
    .push_entry_o     (push_entry)
  );

  // the queue is flushed in the same cycle as the redirect.
  fetch_fifo #(
    .entry_t (fetch_entry_t),
    .DEPTH   (`FETCH_QUEUE_DEPTH)
  ) u_fetch_fifo (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (redirect_i),
    .push_i      (push),
    .push_data_i (push_entry),
    .pop_valid_o (fetch_valid_o),
    .pop_ready_i (fetch_ready_i),
    .pop_data_o  (head_entry),
    .free_o      (free_slots)
  );

  assign fetch_pc_o    = head_entry.pc;
  assign fetch_inst_o  = head_entry.inst;
  assign fetch_fault_o = head_entry.fault;

endmodule

`default_nettype wire

// ==== sim/fetch_mem_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data is a function of the address alone. Responses come back in request order,
// at least one cycle after the request, with latency_i sampled when a request is taken.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_settings.svh"

module fetch_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid_i,
  input  logic                 req_ready_i,
  input  fetch_pkg::addr_t     req_addr_i,
  input  int                   latency_i,
  input  logic                 fault_en_i,
  input  fetch_pkg::addr_t     fault_addr_i,
  output logic                 resp_valid_o,
  output fetch_pkg::mem_data_t resp_data_o,
  output fetch_pkg::mem_resp_t resp_code_o
);

  import fetch_pkg::*;

  addr_t pend_addr[$];
  int    pend_due[$];
  int    cycle;
  int    last_due;

  // one 32-bit instruction word for each 4-byte address.
  function automatic inst_t word_at(addr_t a);
    return ~a[31:0] ^ a[63:32] ^ 32'h1357_9bdf;
  endfunction

  // requests are taken on the rising edge.
  always @(posedge clk) begin
    int due;
    if (rst) begin
      pend_addr.delete();
      pend_due.delete();
      cycle    = 0;
      last_due = 0;
    end else begin
      if (req_valid_i && req_ready_i) begin
        due = cycle + ((latency_i < 1) ? 1 : latency_i);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        pend_addr.push_back(req_addr_i);
        pend_due.push_back(due);
      end
      cycle = cycle + 1;
    end
  end

  // responses change on the falling edge, like every other DUT input.
  always @(negedge clk) begin
    addr_t a;
    resp_valid_o = 1'b0;
    resp_data_o  = '0;
    resp_code_o  = resp_okay;
    if (!rst && (pend_due.size() > 0) && (pend_due[0] <= cycle)) begin
      a = pend_addr.pop_front();
      void'(pend_due.pop_front());
      resp_valid_o = 1'b1;
      resp_data_o  = {word_at({a[63:3], 3'b100}), word_at({a[63:3], 3'b000})};
      if (fault_en_i && (a[63:3] == fault_addr_i[63:3])) begin
        resp_code_o = resp_slverr;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/if_stage_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// handshake checks on if_stage. A redirect may drop a pending request.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_settings.svh"

module if_stage_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 redirect_i,
  input logic                 mem_req_valid_o,
  input logic                 mem_req_ready_i,
  input fetch_pkg::addr_t     mem_req_addr_o,
  input logic                 mem_resp_valid_i,
  input logic                 fetch_valid_o,
  input logic                 fetch_ready_i,
  input fetch_pkg::addr_t     fetch_pc_o,
  input fetch_pkg::inst_t     fetch_inst_o,
  input logic                 fetch_fault_o
);

  int in_flight;

  always @(posedge clk) begin
    if (rst) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(mem_req_valid_o && mem_req_ready_i) - int'(mem_resp_valid_i);
    end
  end

  a_max_outstanding: assert property (@(posedge clk) disable iff (rst)
    in_flight <= `FETCH_MAX_OUTSTANDING)
    else $error("more reads in flight than allowed");

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req_valid_o && !mem_req_ready_i) |=>
      (redirect_i || (mem_req_valid_o && $stable(mem_req_addr_o))))
    else $error("memory request changed while stalled");

  a_fetch_stable: assert property (@(posedge clk) disable iff (rst)
    (fetch_valid_o && !fetch_ready_i && !redirect_i) |=>
      (fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_inst_o) &&
       $stable(fetch_fault_o)))
    else $error("decode entry changed while stalled");

  // both valids stay low while in reset.
  a_reset_quiet: assert property (@(posedge clk)
    rst |-> (!mem_req_valid_o && !fetch_valid_o))
    else $error("handshake active during reset");

endmodule

bind if_stage if_stage_properties u_props (
  .clk              (clk),
  .rst              (rst),
  .redirect_i       (redirect_i),
  .mem_req_valid_o  (mem_req_valid_o),
  .mem_req_ready_i  (mem_req_ready_i),
  .mem_req_addr_o   (mem_req_addr_o),
  .mem_resp_valid_i (mem_resp_valid_i),
  .fetch_valid_o    (fetch_valid_o),
  .fetch_ready_i    (fetch_ready_i),
  .fetch_pc_o       (fetch_pc_o),
  .fetch_inst_o     (fetch_inst_o),
  .fetch_fault_o    (fetch_fault_o)
);

`default_nettype wire

// ==== sim/if_stage_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// directed tests of the fetch front end. Expected entries follow a sequential pc
// model that restarts at the aligned target of each redirect.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_settings.svh"

module if_stage_tb;

  import fetch_pkg::*;

  localparam int TOTAL_ENTRIES = 32 + 40 + 24 + 12;
  localparam int CYCLE_LIMIT   = 2 * TOTAL_ENTRIES * 20;

  logic      clk;
  logic      rst;
  logic      redirect;
  addr_t     redirect_pc;
  logic      mem_req_valid;
  logic      mem_req_ready;
  addr_t     mem_req_addr;
  logic      mem_resp_valid;
  mem_data_t mem_resp_data;
  mem_resp_t mem_resp_code;
  logic      fetch_valid;
  logic      fetch_ready;
  addr_t     fetch_pc;
  inst_t     fetch_inst;
  logic      fetch_fault;

  int    latency;
  logic  fault_en;
  addr_t fault_addr;
  logic  rand_mode;
  int    seed;
  int    errors;
  int    checked;
  int    cycles;
  addr_t exp_pc;
  addr_t req_pc;
  string test_name;

  if_stage u_dut (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_req_addr_o   (mem_req_addr),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_data_i  (mem_resp_data),
    .mem_resp_code_i  (mem_resp_code),
    .fetch_valid_o    (fetch_valid),
    .fetch_ready_i    (fetch_ready),
    .fetch_pc_o       (fetch_pc),
    .fetch_inst_o     (fetch_inst),
    .fetch_fault_o    (fetch_fault)
  );

  fetch_mem_model u_mem (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (mem_req_valid),
    .req_ready_i  (mem_req_ready),
    .req_addr_i   (mem_req_addr),
    .latency_i    (latency),
    .fault_en_i   (fault_en),
    .fault_addr_i (fault_addr),
    .resp_valid_o (mem_resp_valid),
    .resp_data_o  (mem_resp_data),
    .resp_code_o  (mem_resp_code)
  );

  always #50 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // expected values and compares
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic inst_t expected_inst(addr_t pc);
    return ~pc[31:0] ^ pc[63:32] ^ 32'h1357_9bdf;
  endfunction

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_inst(input string what, input inst_t exp, input inst_t act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_fault(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: %s expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // decode side monitor. A pop in a redirect cycle still belongs to the old path.
  always @(posedge clk) begin
    if (rst) begin
      exp_pc = `FETCH_RESET_PC;
    end else begin
      if (fetch_valid && fetch_ready) begin
        check_addr("pc", exp_pc, fetch_pc);
        check_inst("inst", expected_inst(exp_pc), fetch_inst);
        check_fault("fault", fault_en && (exp_pc[63:3] == fault_addr[63:3]), fetch_fault);
        exp_pc = exp_pc + addr_t'(4);
        checked++;
      end
      if (redirect) begin
        exp_pc = {redirect_pc[63:2], 2'b00};
      end
    end
  end

  // request side monitor. Each read asks for the doubleword of the next pc in order.
  always @(posedge clk) begin
    if (rst) begin
      req_pc = `FETCH_RESET_PC;
    end else begin
      if (mem_req_valid && mem_req_ready) begin
        check_addr("request address", {req_pc[63:3], 3'b000}, mem_req_addr);
        req_pc = req_pc + addr_t'(4);
      end
      if (redirect) begin
        req_pc = {redirect_pc[63:2], 2'b00};
      end
    end
  end

  // random stalls on both channels.
  always @(negedge clk) begin
    if (rand_mode && !rst) begin
      fetch_ready   = ($random(seed) & 1) != 0;
      mem_req_ready = ($random(seed) & 1) != 0;
      latency       = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: only %0d entries reached decode in %0d cycles", checked, cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic wait_entries(input int n);
    int target;
    target = checked + n;
    while (checked < target) @(posedge clk);
  endtask

  task automatic send_redirect(input addr_t target);
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect    = 1'b0;
  endtask

  task automatic test_sequential();
    test_name = "sequential";
    wait_entries(32);
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    rand_mode = 1'b1;
    wait_entries(40);
    @(negedge clk);
    rand_mode     = 1'b0;
    fetch_ready   = 1'b1;
    mem_req_ready = 1'b1;
  endtask

  task automatic test_redirect();
    @(negedge clk);
    test_name = "redirect";
    latency   = 3;
    send_redirect(64'h0000_0000_8000_2004);
    wait_entries(8);
    send_redirect(64'h0000_0000_8000_3000);
    wait_entries(8);
    // misaligned target, which lands on 0x...0104.
    send_redirect(64'h0000_0000_8000_0106);
    wait_entries(8);
  endtask

  task automatic test_fault();
    @(negedge clk);
    test_name  = "fault";
    latency    = 2;
    fault_addr = 64'h0000_0000_8000_1000;
    fault_en   = 1'b1;
    send_redirect(64'h0000_0000_8000_0ff0);
    wait_entries(12);
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    redirect      = 1'b0;
    redirect_pc   = '0;
    mem_req_ready = 1'b0;
    fetch_ready   = 1'b0;
    latency       = 1;
    fault_en      = 1'b0;
    fault_addr    = '0;
    rand_mode     = 1'b0;
    seed          = 5;
    errors        = 0;
    checked       = 0;
    cycles        = 0;
    test_name     = "reset";
    repeat (16) @(negedge clk);
    rst           = 1'b0;
    mem_req_ready = 1'b1;
    fetch_ready   = 1'b1;

    test_sequential();
    test_backpressure();
    test_redirect();
    test_fault();

    $display("errors: %0d, entries checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/fetch_pkg.sv
design/pc_gen.sv
design/fetch_req_unit.sv
design/fetch_fifo.sv
design/if_stage.sv
sim/fetch_mem_model.sv
sim/if_stage_properties.sv
sim/if_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module if_stage_tb \
  -o if_stage_tb_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/if_stage_tb_sim > sim.log 2>&1 || echo "simulator returned nonzero"

grep -q "Finished with no errors" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }
